//--- filelist.f
hw/tensor_pkg.sv
hw/stripe_sequencer.sv
hw/operand_block_regs.sv
hw/pe_lane.sv
hw/result_credit_tx.sv
hw/tensor_stripe.sv
sim/tb_tensor_stripe_sva.sv
sim/tb_tensor_stripe.sv

//--- hw/operand_block_regs.sv
`timescale 1ns/1ps
`default_nettype none

module operand_block_regs (
  input  logic                              clk,
  input  logic                              rst_n,
  input  tensor_pkg::bus_beat_t             bus_0,
  input  tensor_pkg::bus_beat_t             bus_1,
  input  logic                              load_a,
  input  logic                              load_b,
  input  logic                              swap_a,
  input  logic                              swap_b,
  input  logic                              clear_blocks,
  input  logic                              scalar_en,
  input  logic [tensor_pkg::LANE_SEL_W-1:0] scalar_lane,
  output tensor_pkg::block_t                lane_a,
  output tensor_pkg::block_t                lane_b
);

  tensor_pkg::block_t blk_a_q;
  tensor_pkg::block_t blk_b_q;
  tensor_pkg::block_t src_a;
  tensor_pkg::block_t src_b;
  tensor_pkg::fix_t   scalar_val;

  // A normally rides bus 0, B rides bus 1
  assign src_a = swap_a ? bus_1.data : bus_0.data;
  assign src_b = swap_b ? bus_0.data : bus_1.data;

  always_ff @(posedge clk) begin
    if (!rst_n || clear_blocks) begin
      blk_a_q <= '0;
      blk_b_q <= '0;
    end else begin
      if (load_a)
        blk_a_q <= src_a;
      if (load_b)
        blk_b_q <= src_b;
    end
  end

  assign scalar_val = blk_a_q[scalar_lane];

  // Broadcast one A value to every lane when requested
  always_comb begin
    for (int i = 0; i < tensor_pkg::LANES; i++) begin
      lane_a[i] = scalar_en ? scalar_val : blk_a_q[i];
    end
  end

  assign lane_b = blk_b_q;

endmodule

`default_nettype wire

//--- hw/pe_lane.sv
`timescale 1ns/1ps
`default_nettype none

module pe_lane (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               step,
  input  logic               acc_clear,
  input  tensor_pkg::instr_t instr,
  input  tensor_pkg::fix_t   a,
  input  tensor_pkg::fix_t   b,
  output tensor_pkg::fix_t   q
);

  tensor_pkg::acc_t                   a_w;
  tensor_pkg::acc_t                   b_w;
  tensor_pkg::acc_t                   mul_w;
  tensor_pkg::acc_t                   op_res;
  tensor_pkg::acc_t                   acc_q;
  logic [2*(tensor_pkg::DATA_W-1)-1:0] prod; // 30 bits, already 28 fraction bits
  logic [tensor_pkg::ACC_W-1:0]       acc_abs;
  logic                               round_up;
  logic [tensor_pkg::ACC_W-tensor_pkg::ACC_SHIFT:0] rounded;
  logic [tensor_pkg::DATA_W-2:0]      mag_out;

  // Sign-magnitude to two's complement at accumulator scale
  function automatic tensor_pkg::acc_t widen(input tensor_pkg::fix_t v);
    tensor_pkg::acc_t m;
    m = tensor_pkg::acc_t'({v.mag, {tensor_pkg::ACC_SHIFT{1'b0}}});
    return v.sign ? -m : m;
  endfunction

  assign a_w = widen(a);
  assign b_w = widen(b);

  assign prod  = a.mag * b.mag;
  assign mul_w = (a.sign ^ b.sign) ? -tensor_pkg::acc_t'(prod) : tensor_pkg::acc_t'(prod);

  always_comb begin
    case (instr.op)
      tensor_pkg::ALU_ADD: op_res = a_w + b_w;
      tensor_pkg::ALU_SUB: op_res = a_w - b_w;
      tensor_pkg::ALU_MUL: op_res = mul_w;
      default:             op_res = '0;
    endcase
  end

  // Accumulator wraps at 32 bits
  always_ff @(posedge clk) begin
    if (!rst_n || acc_clear)
      acc_q <= '0;
    else if (step)
      acc_q <= instr.accumulate ? acc_q + op_res : op_res;
  end

  assign acc_abs = acc_q[tensor_pkg::ACC_W-1] ? -acc_q : acc_q;

  // Round to nearest, ties to even, at bit ACC_SHIFT
  assign round_up = acc_abs[tensor_pkg::ACC_SHIFT-1] &
                    ((|acc_abs[tensor_pkg::ACC_SHIFT-2:0]) | acc_abs[tensor_pkg::ACC_SHIFT]);

  assign rounded = {1'b0, acc_abs[tensor_pkg::ACC_W-1:tensor_pkg::ACC_SHIFT]} +
                   {{(tensor_pkg::ACC_W-tensor_pkg::ACC_SHIFT){1'b0}}, round_up};

  always_comb begin
    if (|rounded[tensor_pkg::ACC_W-tensor_pkg::ACC_SHIFT:tensor_pkg::DATA_W-1])
      mag_out = '1; // Saturate at 32767
    else
      mag_out = rounded[tensor_pkg::DATA_W-2:0];
  end

  // Negative values rounding to zero come out as plus zero
  assign q.sign = acc_q[tensor_pkg::ACC_W-1] & (|mag_out);
  assign q.mag  = mag_out;

endmodule

`default_nettype wire

//--- hw/result_credit_tx.sv
`timescale 1ns/1ps
`default_nettype none

module result_credit_tx (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               finish,
  input  tensor_pkg::block_t lane_q,
  input  logic               res_credit,
  output logic               res_valid,
  output tensor_pkg::block_t res_data,
  output logic               tx_busy
);

  logic [tensor_pkg::BLOCK_W-1:0]  hold_q;
  logic                            pending_q;  // Result waiting for a credit
  logic                            res_valid_q;
  logic [tensor_pkg::CREDIT_W-1:0] credit_q;
  logic                            send;

  // Pending and valid never overlap, so the raw count is what is free
  assign send = pending_q && (credit_q != '0);

  always_ff @(posedge clk) begin
    if (finish)
      hold_q <= lane_q;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      credit_q    <= tensor_pkg::CREDIT_W'(tensor_pkg::RESULT_CREDITS);
      pending_q   <= 1'b0;
      res_valid_q <= 1'b0;
    end else begin
      // Credit leaves at the end of the valid cycle
      credit_q <= credit_q - tensor_pkg::CREDIT_W'(res_valid_q)
                           + tensor_pkg::CREDIT_W'(res_credit);
      if (finish)
        pending_q <= 1'b1;
      else if (send)
        pending_q <= 1'b0;
      res_valid_q <= send; // One-cycle pulse
    end
  end

  assign res_valid = res_valid_q;
  assign res_data  = hold_q;
  assign tx_busy   = pending_q | res_valid_q;

endmodule

`default_nettype wire

//--- hw/stripe_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module stripe_sequencer (
  input  logic                              clk,
  input  logic                              rst_n,
  input  tensor_pkg::stripe_cfg_t           cfg,
  input  logic                              cfg_valid,
  input  tensor_pkg::bus_beat_t             bus_0,
  input  tensor_pkg::bus_beat_t             bus_1,
  input  logic                              tx_busy,
  output logic                              cfg_ready,
  output logic                              load_a,
  output logic                              load_b,
  output logic                              swap_a,
  output logic                              swap_b,
  output logic                              clear_blocks,
  output logic                              step,
  output logic                              acc_clear,
  output logic                              finish,
  output tensor_pkg::instr_t                instr,
  output logic                              scalar_en,
  output logic [tensor_pkg::LANE_SEL_W-1:0] scalar_lane
);

  logic             busy_q;
  logic             have_a_q;
  logic             have_b_q;
  tensor_pkg::tag_t tag_a_q;
  tensor_pkg::tag_t tag_b_q;
  tensor_pkg::tag_t stride_a_q;
  tensor_pkg::tag_t stride_b_q;
  tensor_pkg::tag_t iter_lim_q;
  tensor_pkg::tag_t iter_cnt_q;
  tensor_pkg::tag_t iter_nxt;
  logic             accept;
  logic             active;
  logic             done;
  logic             last_step;
  logic             hit_a0;
  logic             hit_a1;
  logic             hit_b0;
  logic             hit_b1;

  assign cfg_ready    = ~busy_q & ~tx_busy; // Sender backlog also blocks new jobs
  assign accept       = cfg_valid & cfg_ready;
  assign clear_blocks = accept;
  assign acc_clear    = accept;

  // Either bus may carry either operand
  assign hit_a0 = bus_0.valid && (bus_0.tag == tag_a_q);
  assign hit_a1 = bus_1.valid && (bus_1.tag == tag_a_q);
  assign hit_b0 = bus_0.valid && (bus_0.tag == tag_b_q);
  assign hit_b1 = bus_1.valid && (bus_1.tag == tag_b_q);

  assign active = busy_q && (iter_cnt_q < iter_lim_q);

  assign load_a = active & ~have_a_q & (hit_a0 | hit_a1);
  assign swap_a = ~hit_a0 & hit_a1; // Home bus wins on a double hit
  assign load_b = active & ~have_b_q & (hit_b0 | hit_b1);
  assign swap_b = ~hit_b1 & hit_b0;

  assign step      = active & have_a_q & have_b_q & ~tx_busy;
  assign iter_nxt  = iter_cnt_q + 1'b1;
  assign last_step = step && (iter_nxt == iter_lim_q);
  assign done      = busy_q && (iter_cnt_q == iter_lim_q); // Also true at once for zero iterations
  assign finish    = done & instr.emit;

  // Job registers, loaded once per job
  always_ff @(posedge clk) begin
    if (accept) begin
      stride_a_q  <= cfg.stride_a;
      stride_b_q  <= cfg.stride_b;
      iter_lim_q  <= cfg.iter_lim;
      instr       <= cfg.instr;
      scalar_en   <= cfg.scalar_en;
      scalar_lane <= cfg.scalar_lane;
    end
  end

  // Current tags walk by their strides
  always_ff @(posedge clk) begin
    if (accept) begin
      tag_a_q <= cfg.tag_a;
      tag_b_q <= cfg.tag_b;
    end else if (step) begin
      tag_a_q <= tag_a_q + stride_a_q;
      tag_b_q <= tag_b_q + stride_b_q;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy_q     <= 1'b0;
      have_a_q   <= 1'b0;
      have_b_q   <= 1'b0;
      iter_cnt_q <= '0;
    end else if (accept) begin
      busy_q     <= 1'b1;
      have_a_q   <= 1'b0;
      have_b_q   <= 1'b0;
      iter_cnt_q <= '0;
    end else begin
      if (load_a)
        have_a_q <= 1'b1;
      if (load_b)
        have_b_q <= 1'b1;
      if (step) begin
        have_a_q   <= 1'b0; // Both flags set here, so no load this cycle
        have_b_q   <= 1'b0;
        iter_cnt_q <= iter_nxt;
      end
      // Emit jobs hand over to the sender one cycle after the last step
      if (done || (last_step && !instr.emit))
        busy_q <= 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- hw/tensor_pkg.sv
`default_nettype none

package tensor_pkg;

  // Value and lane geometry
  localparam int DATA_W     = 16;             // Sign plus Q1.14 magnitude
  localparam int LANES      = 8;
  localparam int BLOCK_W    = LANES * DATA_W; // 128
  localparam int ACC_W      = 32;
  localparam int FRAC_IN    = 14;
  localparam int ACC_FRAC   = 28;
  localparam int ACC_SHIFT  = ACC_FRAC - FRAC_IN; // Operand to accumulator alignment
  localparam int TAG_W      = 12;
  localparam int LANE_SEL_W = 3;

  // Result port credits
  localparam int RESULT_CREDITS = 2;
  localparam int CREDIT_W       = $clog2(RESULT_CREDITS + 1);

  typedef struct packed {
    logic              sign;
    logic [DATA_W-2:0] mag;  // Q1.14
  } fix_t;

  typedef logic signed [ACC_W-1:0] acc_t; // Two's complement, 28 fraction bits

  typedef logic [TAG_W-1:0] tag_t;

  typedef enum logic [1:0] {
    ALU_ADD = 2'd0,
    ALU_SUB = 2'd1,
    ALU_MUL = 2'd2
  } alu_op_t;

  typedef struct packed {
    alu_op_t op;
    logic    accumulate; // Add old accumulator to the result
    logic    emit;       // Return result block at job end
  } instr_t;

  // Lane 0 sits in the low bits
  typedef fix_t [LANES-1:0] block_t;

  typedef struct packed {
    logic   valid;
    tag_t   tag;
    block_t data;
  } bus_beat_t;

  typedef struct packed {
    tag_t                  tag_a;
    tag_t                  tag_b;
    tag_t                  stride_a;
    tag_t                  stride_b;
    tag_t                  iter_lim;
    instr_t                instr;
    logic                  scalar_en;
    logic [LANE_SEL_W-1:0] scalar_lane;
  } stripe_cfg_t;

endpackage

`default_nettype wire

//--- hw/tensor_stripe.sv
`timescale 1ns/1ps
`default_nettype none

module tensor_stripe (
  input  logic                    clk,
  input  logic                    rst_n,
  input  tensor_pkg::stripe_cfg_t cfg,
  input  logic                    cfg_valid,
  output logic                    cfg_ready,
  input  tensor_pkg::bus_beat_t   bus_0,
  input  tensor_pkg::bus_beat_t   bus_1,
  output logic                    res_valid,
  output tensor_pkg::block_t      res_data,
  input  logic                    res_credit
);

  logic                              load_a;
  logic                              load_b;
  logic                              swap_a;
  logic                              swap_b;
  logic                              clear_blocks;
  logic                              step;
  logic                              acc_clear;
  logic                              finish;
  logic                              tx_busy;
  logic                              scalar_en;
  logic [tensor_pkg::LANE_SEL_W-1:0] scalar_lane;
  tensor_pkg::instr_t                instr;
  tensor_pkg::block_t                lane_a;
  tensor_pkg::block_t                lane_b;
  wire tensor_pkg::block_t           lane_q;  // One element per lane instance

  stripe_sequencer seq_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .cfg          (cfg),
    .cfg_valid    (cfg_valid),
    .bus_0        (bus_0),
    .bus_1        (bus_1),
    .tx_busy      (tx_busy),
    .cfg_ready    (cfg_ready),
    .load_a       (load_a),
    .load_b       (load_b),
    .swap_a       (swap_a),
    .swap_b       (swap_b),
    .clear_blocks (clear_blocks),
    .step         (step),
    .acc_clear    (acc_clear),
    .finish       (finish),
    .instr        (instr),
    .scalar_en    (scalar_en),
    .scalar_lane  (scalar_lane)
  );

  operand_block_regs blk_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .bus_0        (bus_0),
    .bus_1        (bus_1),
    .load_a       (load_a),
    .load_b       (load_b),
    .swap_a       (swap_a),
    .swap_b       (swap_b),
    .clear_blocks (clear_blocks),
    .scalar_en    (scalar_en),
    .scalar_lane  (scalar_lane),
    .lane_a       (lane_a),
    .lane_b       (lane_b)
  );

  for (genvar i = 0; i < tensor_pkg::LANES; i++) begin : g_lane
    pe_lane pe_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .step      (step),
      .acc_clear (acc_clear),
      .instr     (instr),
      .a         (lane_a[i]),
      .b         (lane_b[i]),
      .q         (lane_q[i])
    );
  end

  result_credit_tx tx_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .finish     (finish),
    .lane_q     (lane_q),
    .res_credit (res_credit),
    .res_valid  (res_valid),
    .res_data   (res_data),
    .tx_busy    (tx_busy)
  );

endmodule

`default_nettype wire

//--- sim/tb_tensor_stripe.sv
`timescale 1ns/1ps
`default_nettype none

module tb_tensor_stripe;

  logic                    clk;
  logic                    rst_n;
  tensor_pkg::stripe_cfg_t cfg;
  logic                    cfg_valid;
  logic                    cfg_ready;
  tensor_pkg::bus_beat_t   bus_0;
  tensor_pkg::bus_beat_t   bus_1;
  logic                    res_valid;
  tensor_pkg::block_t      res_data;
  logic                    res_credit;

  tensor_pkg::block_t blk_a [4];
  tensor_pkg::block_t blk_b [4];
  tensor_pkg::block_t got_q [$];
  tensor_pkg::block_t exp_q [$];
  string              name_q [$];
  int                 cycle = 0;
  int                 results_seen = 0;
  int                 credits_given = 0;
  int                 last_cap;
  int                 last_res;
  int                 base;
  bit                 auto_credit;
  tensor_pkg::stripe_cfg_t c;

  tensor_stripe dut_i (.*);

  always #5 clk = ~clk;

  task automatic stop_fail();
    $display("=== FAIL ===");
    $fatal(1);
  endtask

  always @(posedge clk) begin
    cycle++;
    if (cycle >= 4000) begin
      $display("Timeout: run did not finish within 4000 cycles");
      stop_fail();
    end
  end

  // Consumer returns one credit per result it has seen
  always @(posedge clk) begin
    #1;
    if (auto_credit && credits_given < results_seen) begin
      res_credit = 1'b1;
      credits_given++;
    end else
      res_credit = 1'b0;
  end

  always @(negedge clk) begin
    if (res_valid) begin
      got_q.push_back(res_data);
      results_seen++;
      last_res = cycle;
    end
  end

  // Reference value at accumulator scale, 28 fraction bits
  function automatic logic signed [31:0] lane_val(input tensor_pkg::fix_t v);
    longint m;
    m = longint'(v.mag) * 16384;
    return v.sign ? -m : m;
  endfunction

  function automatic logic signed [31:0] lane_step(input tensor_pkg::instr_t ins,
      input logic signed [31:0] old, input tensor_pkg::fix_t a, input tensor_pkg::fix_t b);
    longint r;
    case (ins.op)
      tensor_pkg::ALU_ADD: r = longint'(lane_val(a)) + lane_val(b);
      tensor_pkg::ALU_SUB: r = longint'(lane_val(a)) - lane_val(b);
      default: begin
        r = longint'(a.mag) * longint'(b.mag);
        if (a.sign ^ b.sign)
          r = -r;
      end
    endcase
    return ins.accumulate ? old + r : r;
  endfunction

  function automatic tensor_pkg::fix_t model_round(input logic signed [31:0] acc);
    longint mag;
    longint q;
    longint rem;
    tensor_pkg::fix_t r;
    mag = (acc < 0) ? -longint'(acc) : longint'(acc);
    q   = mag >> 14;
    rem = mag % 16384;
    if (rem > 8192 || (rem == 8192 && q[0]))
      q++; // Ties go to even
    if (q > 32767)
      q = 32767;
    r.mag  = q[14:0];
    r.sign = (acc < 0) && (q != 0);
    return r;
  endfunction

  task automatic fill_random();
    for (int k = 0; k < 4; k++)
      for (int l = 0; l < 8; l++) begin
        blk_a[k][l] = '{sign: 1'($urandom % 2), mag: 15'($urandom % 16384)};
        blk_b[k][l] = '{sign: 1'($urandom % 2), mag: 15'($urandom % 16384)};
      end
  endtask

  task automatic run_job(input string name, input tensor_pkg::stripe_cfg_t jc,
                         input bit swap, input bit junk);
    logic signed [31:0]    acc [8];
    tensor_pkg::block_t    expv;
    tensor_pkg::fix_t      a;
    tensor_pkg::bus_beat_t beat_a;
    tensor_pkg::bus_beat_t beat_b;
    bit                    ready;
    for (int l = 0; l < 8; l++)
      acc[l] = 0;
    for (int k = 0; k < jc.iter_lim; k++)
      for (int l = 0; l < 8; l++) begin
        a      = jc.scalar_en ? blk_a[k][jc.scalar_lane] : blk_a[k][l];
        acc[l] = lane_step(jc.instr, acc[l], a, blk_b[k][l]);
      end
    if (jc.instr.emit) begin
      for (int l = 0; l < 8; l++)
        expv[l] = model_round(acc[l]);
      exp_q.push_back(expv);
      name_q.push_back(name);
    end
    cfg       = jc;
    cfg_valid = 1'b1;
    do begin
      ready = cfg_ready;
      @(posedge clk);
      #1;
    end while (!ready);
    cfg_valid = 1'b0;
    for (int k = 0; k < jc.iter_lim; k++) begin
      beat_a = '{1'b1, tensor_pkg::tag_t'(jc.tag_a + k * jc.stride_a), blk_a[k]};
      beat_b = '{1'b1, tensor_pkg::tag_t'(jc.tag_b + k * jc.stride_b), blk_b[k]};
      if (junk) begin
        bus_0 = '{1'b1, 12'hfff, ~blk_b[k]};           // Foreign tag
        bus_1 = '{1'b1, beat_a.tag - 1'b1, ~blk_a[k]}; // Stale A tag
        @(posedge clk);
        #1;
      end
      bus_0 = swap ? beat_b : beat_a;
      bus_1 = swap ? beat_a : beat_b;
      @(posedge clk);
      #1;
      last_cap = cycle;
      bus_0    = '0;
      bus_1    = '0;
      repeat (2) begin
        @(posedge clk);
        #1;
      end
    end
  endtask

  task automatic check_results();
    tensor_pkg::block_t g;
    tensor_pkg::block_t e;
    string              n;
    while (exp_q.size() > 0) begin
      while (got_q.size() == 0) begin
        @(posedge clk);
        #1;
      end
      g = got_q.pop_front();
      e = exp_q.pop_front();
      n = name_q.pop_front();
      for (int l = 0; l < 8; l++)
        assert (g[l] == e[l]) else begin
          $display("** Error [%s] lane %0d: expected %h, actual %h", n, l, e[l], g[l]);
          stop_fail();
        end
    end
  endtask

  initial begin
    void'($urandom(80));
    clk = 1'b0;
    rst_n = 1'b0;
    cfg = '0;
    cfg_valid = 1'b0;
    bus_0 = '0;
    bus_1 = '0;
    res_credit = 1'b0;
    auto_credit = 1'b1;
    repeat (3) @(posedge clk);
    #1 rst_n = 1'b1;

    fill_random();
    c = '0;
    c.tag_a = 12'h100;
    c.tag_b = 12'h200;
    c.stride_a = 12'd1;
    c.stride_b = 12'd2;
    c.iter_lim = 12'd4;
    c.instr = '{tensor_pkg::ALU_MUL, 1'b1, 1'b1};
    run_job("mac", c, 1'b0, 1'b0);
    check_results();
    assert (last_res - last_cap == 3) else begin
      $display("** Error [mac] beat to result latency: expected 3, actual %0d",
               last_res - last_cap);
      stop_fail();
    end
    run_job("cross_bus", c, 1'b1, 1'b1);
    check_results();

    fill_random();
    c.scalar_en = 1'b1;
    c.scalar_lane = 3'd5;
    c.iter_lim = 12'd2;
    c.instr = '{tensor_pkg::ALU_ADD, 1'b1, 1'b1};
    run_job("scalar", c, 1'b0, 1'b0);
    check_results();

    // Saturation, signed difference and minus zero
    fill_random();
    c.scalar_en = 1'b0;
    c.iter_lim = 12'd1;
    c.instr = '{tensor_pkg::ALU_SUB, 1'b0, 1'b1};
    blk_a[0][0] = '{1'b0, 15'd32767};
    blk_b[0][0] = '{1'b1, 15'd32767};
    blk_a[0][1] = '{1'b0, 15'd0};
    blk_b[0][1] = '{1'b0, 15'd0};
    blk_a[0][2] = '{1'b1, 15'd100};
    blk_b[0][2] = '{1'b0, 15'd50};
    blk_a[0][3] = '{1'b1, 15'd0};
    blk_b[0][3] = '{1'b0, 15'd0};
    run_job("sub_sign", c, 1'b0, 1'b0);
    // Exact ties from products
    c.instr = '{tensor_pkg::ALU_MUL, 1'b0, 1'b1};
    blk_a[0][0] = '{1'b1, 15'h2000};
    blk_b[0][0] = '{1'b0, 15'd1};
    blk_a[0][1] = '{1'b0, 15'h2000};
    blk_b[0][1] = '{1'b0, 15'd3};
    blk_a[0][2] = '{1'b1, 15'h2000};
    blk_b[0][2] = '{1'b0, 15'd5};
    blk_a[0][3] = '{1'b0, 15'h6000};
    blk_b[0][3] = '{1'b0, 15'h6000};
    run_job("round_tie", c, 1'b0, 1'b0);
    check_results();

    repeat (4) @(posedge clk);
    #1 auto_credit = 1'b0;
    base = results_seen;
    for (int j = 0; j < 3; j++) begin
      fill_random();
      c.tag_a = tensor_pkg::tag_t'(12'h300 + j);
      c.tag_b = tensor_pkg::tag_t'(12'h400 + j);
      run_job("credit", c, 1'b0, 1'b0);
    end
    repeat (10) @(posedge clk);
    #1;
    assert (results_seen == base + 2) else begin
      $display("** Error [credit] results without credit return: expected 2, actual %0d",
               results_seen - base);
      stop_fail();
    end
    assert (!cfg_ready) else begin
      $display("cfg_ready went high while the third result waited for a credit");
      stop_fail();
    end
    auto_credit = 1'b1;
    check_results();

    repeat (5) @(posedge clk);
    if (got_q.size() == 0) begin
      $display("=== PASS ===");
      $finish;
    end else begin
      $display("DUT returned %0d results that no job expected", got_q.size());
      stop_fail();
    end
  end

endmodule

`default_nettype wire

//--- sim/tb_tensor_stripe_sva.sv
`timescale 1ns/1ps
`default_nettype none

module tb_tensor_stripe_sva (
  input logic                            clk,
  input logic                            rst_n,
  input logic                            res_valid,
  input logic                            cfg_ready,
  input logic                            pending,
  input logic [tensor_pkg::CREDIT_W-1:0] credit
);

  // A result only goes out against a held credit
  a_valid_needs_credit : assert property (
    @(posedge clk) disable iff (!rst_n) res_valid |-> (credit != '0)
  ) else $error("res_valid high with no credit held");

  a_credit_bound : assert property (
    @(posedge clk) disable iff (!rst_n) credit <= tensor_pkg::RESULT_CREDITS
  ) else $error("credit count above the initial credits");

  // Held result blocks new jobs
  a_ready_low_when_held : assert property (
    @(posedge clk) disable iff (!rst_n) pending |-> !cfg_ready
  ) else $error("cfg_ready high while a result is held");

  a_quiet_after_reset : assert property (
    @(posedge clk) !rst_n |=> !res_valid
  ) else $error("res_valid high in the cycle after reset");

endmodule

bind tensor_stripe tb_tensor_stripe_sva sva_i (
  .clk       (clk),
  .rst_n     (rst_n),
  .res_valid (res_valid),
  .cfg_ready (cfg_ready),
  .pending   (tx_i.pending_q),
  .credit    (tx_i.credit_q)
);

`default_nettype wire
